//--- Makefile
# Verilator build for the matrix multiplication accelerator.

TOP := tb_matrix_multiplication

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

obj_dir/$(TOP): src.f $(shell cat src.f) test/mm_patterns.mem
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)

sim: obj_dir/$(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- src.f
src/mm_cfg_pkg.sv
src/mm_regs_pkg.sv
src/mm_pe.sv
src/mm_apb_decode.sv
src/mm_systolic_execute.sv
src/mm_result_writer.sv
src/matrix_multiplication.sv
test/tb_matrix_multiplication.sv

//--- src/matrix_multiplication.sv
/* Matrix multiplication accelerator top.
   Connects the APB decode, systolic execute and result writer stages. */
module matrix_multiplication
    import mm_cfg_pkg::*;
    import mm_regs_pkg::*;
(
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_awidth-1:0] paddr,
    input  logic [apb_dwidth-1:0] pwdata,
    output logic [apb_dwidth-1:0] prdata,
    output logic                  a_en,
    output logic [awidth-1:0]     a_addr,
    input  mm_row_t               a_data,
    output logic                  b_en,
    output logic [awidth-1:0]     b_addr,
    input  mm_row_t               b_data,
    output logic                  c_en,
    output logic [awidth-1:0]     c_addr,
    output mm_row_t               c_data
);

    logic                      start;
    logic                      done;
    logic                      saturated;
    logic                      acc_valid;
    logic [awidth-1:0]         address_a;
    logic [awidth-1:0]         address_b;
    logic [awidth-1:0]         address_c;
    logic [stride_width-1:0]   stride_a;
    logic [stride_width-1:0]   stride_b;
    logic [stride_width-1:0]   stride_c;
    mm_acc_row_t [mm_size-1:0] acc_rows;

    mm_apb_decode i_decode (
        .pclk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .start, .address_a, .address_b, .address_c,
        .stride_a, .stride_b, .stride_c,
        .done, .saturated
    );

    // Fetch and compute.
    mm_systolic_execute i_execute (
        .pclk, .rst_n, .start,
        .address_a, .address_b, .stride_a, .stride_b,
        .a_en, .a_addr, .b_en, .b_addr, .a_data, .b_data,
        .acc_valid, .acc_rows
    );

    mm_result_writer i_result (
        .pclk, .rst_n, .acc_valid, .acc_rows,
        .address_c, .stride_c,
        .c_en, .c_addr, .c_data,
        .done, .saturated
    );

endmodule

//--- src/mm_apb_decode.sv
/* APB register front end.
   Holds bases and strides, issues the start pulse and tracks run status. */
module mm_apb_decode
    import mm_cfg_pkg::*;
    import mm_regs_pkg::*;
(
    input  logic                    pclk,
    input  logic                    rst_n,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [apb_awidth-1:0]   paddr,
    input  logic [apb_dwidth-1:0]   pwdata,
    output logic [apb_dwidth-1:0]   prdata,
    output logic                    start,
    output logic [awidth-1:0]       address_a,
    output logic [awidth-1:0]       address_b,
    output logic [awidth-1:0]       address_c,
    output logic [stride_width-1:0] stride_a,
    output logic [stride_width-1:0] stride_b,
    output logic [stride_width-1:0] stride_c,
    input  logic                    done,
    input  logic                    saturated
);

    logic wr_en;
    logic busy;
    logic done_flag;
    logic sat_flag;

    // Writes complete in the access phase.
    assign wr_en = psel && penable && pwrite;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            address_a <= '0;
            address_b <= '0;
            address_c <= '0;
            stride_a  <= '0;
            stride_b  <= '0;
            stride_c  <= '0;
        end else if (wr_en) begin
            case (paddr)
                reg_addr_a: address_a <= pwdata[awidth-1:0];
                reg_addr_b: address_b <= pwdata[awidth-1:0];
                reg_addr_c: address_c <= pwdata[awidth-1:0];
                reg_strides: begin
                    stride_a <= pwdata[stride_a_lsb +: stride_width];
                    stride_b <= pwdata[stride_b_lsb +: stride_width];
                    stride_c <= pwdata[stride_c_lsb +: stride_width];
                end
                default: ;
            endcase
        end
    end

    // Start is dropped while a run is in flight, including its own start cycle.
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            start     <= 1'b0;
            busy      <= 1'b0;
            done_flag <= 1'b0;
            sat_flag  <= 1'b0;
        end else begin
            start <= wr_en && (paddr == reg_ctrl) && pwdata[ctrl_start_bit] && !busy && !start;
            if (start) begin
                busy      <= 1'b1;
                done_flag <= 1'b0;
                sat_flag  <= 1'b0;
            end else if (done) begin
                busy      <= 1'b0;
                done_flag <= 1'b1;
                sat_flag  <= sat_flag | saturated;
            end
        end
    end

    // Unmapped offsets and the control register read zero.
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_status: begin
                prdata[status_done_bit] = done_flag;
                prdata[status_sat_bit]  = sat_flag;
                prdata[status_busy_bit] = busy;
            end
            reg_addr_a: prdata[awidth-1:0] = address_a;
            reg_addr_b: prdata[awidth-1:0] = address_b;
            reg_addr_c: prdata[awidth-1:0] = address_c;
            reg_strides: begin
                prdata[stride_a_lsb +: stride_width] = stride_a;
                prdata[stride_b_lsb +: stride_width] = stride_b;
                prdata[stride_c_lsb +: stride_width] = stride_c;
            end
            default: ;
        endcase
    end

    // Setup phase must be followed by the access phase of the same transfer.
    assert property (@(posedge pclk) disable iff (!rst_n)
        psel && !penable |=> psel && penable);

endmodule

//--- src/mm_cfg_pkg.sv
/* Matrix multiplication configuration.
   Array size, element, address and accumulator widths, and the row types. */
package mm_cfg_pkg;

    localparam int mm_size      = 4;
    localparam int dwidth       = 8;
    localparam int awidth       = 10;
    localparam int stride_width = 8;

    // Four 16-bit signed products fit with headroom.
    localparam int acc_width = 20;

    // Step counter for fetch and write-out.
    localparam int k_width = $clog2(mm_size);

    // Cycles after the last fetch until cell (3,3) is final, minus one.
    // One for memory latency, then row skew, then the array diagonal.
    localparam int drain_cycles = 2 * mm_size - 1;
    localparam int drain_width  = $clog2(drain_cycles + 1);

    // Saturation limits of one signed element.
    localparam int elem_max = 2 ** (dwidth - 1) - 1;
    localparam int elem_min = -(2 ** (dwidth - 1));

    // One memory word, element 0 in the low byte.
    typedef logic [mm_size-1:0][dwidth-1:0] mm_row_t;

    typedef logic signed [acc_width-1:0] mm_acc_t;

    // One row of C before saturation.
    typedef mm_acc_t [mm_size-1:0] mm_acc_row_t;

endpackage

//--- src/mm_pe.sv
/* Systolic array cell.
   Multiply-accumulates one A and one B element, passes A right and B down. */
module mm_pe
    import mm_cfg_pkg::*;
(
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic                     clear,
    input  logic signed [dwidth-1:0] a_in,
    input  logic signed [dwidth-1:0] b_in,
    input  logic                     valid_in,
    output logic signed [dwidth-1:0] a_out,
    output logic signed [dwidth-1:0] b_out,
    output logic                     valid_out,
    output mm_acc_t                  acc
);

    logic signed [2*dwidth-1:0] product;

    assign product = (2*dwidth)'(a_in) * (2*dwidth)'(b_in);

    // Operand forwarding to the neighbours.
    always_ff @(posedge pclk) begin
        a_out <= a_in;
        b_out <= b_in;
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            acc       <= '0;
        end else begin
            valid_out <= valid_in;
            if (clear) begin
                acc <= '0;
            end else if (valid_in) begin
                acc <= acc + mm_acc_t'(product);
            end
        end
    end

endmodule

//--- src/mm_regs_pkg.sv
/* APB register map of the accelerator.
   Offsets and field positions of control, status and configuration. */
package mm_regs_pkg;

    localparam int apb_awidth = 8;
    localparam int apb_dwidth = 32;

    localparam logic [apb_awidth-1:0] reg_ctrl    = 8'h00;
    localparam logic [apb_awidth-1:0] reg_status  = 8'h04;
    localparam logic [apb_awidth-1:0] reg_addr_a  = 8'h08;
    localparam logic [apb_awidth-1:0] reg_addr_b  = 8'h0C;
    localparam logic [apb_awidth-1:0] reg_addr_c  = 8'h10;
    localparam logic [apb_awidth-1:0] reg_strides = 8'h14;

    localparam int ctrl_start_bit  = 0;
    localparam int status_done_bit = 0;
    localparam int status_sat_bit  = 1;
    localparam int status_busy_bit = 2;

    // Stride fields inside reg_strides.
    localparam int stride_a_lsb = 0;
    localparam int stride_b_lsb = 8;
    localparam int stride_c_lsb = 16;

endpackage

//--- src/mm_result_writer.sv
/* Result stage of the accelerator.
   Saturates the four accumulator rows, writes them to memory C, then pulses done. */
module mm_result_writer
    import mm_cfg_pkg::*;
(
    input  logic                      pclk,
    input  logic                      rst_n,
    input  logic                      acc_valid,
    input  mm_acc_row_t [mm_size-1:0] acc_rows,
    input  logic [awidth-1:0]         address_c,
    input  logic [stride_width-1:0]   stride_c,
    output logic                      c_en,
    output logic [awidth-1:0]         c_addr,
    output mm_row_t                   c_data,
    output logic                      done,
    output logic                      saturated
);

    mm_acc_row_t [mm_size-1:0] rows_q;
    logic                      writing;
    logic [k_width-1:0]        idx;
    logic                      sat_run;
    logic                      row_clip;

    always_ff @(posedge pclk) begin
        if (acc_valid) begin
            rows_q <= acc_rows;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            writing   <= 1'b0;
            idx       <= '0;
            sat_run   <= 1'b0;
            done      <= 1'b0;
            saturated <= 1'b0;
        end else begin
            done      <= 1'b0;
            saturated <= 1'b0;
            if (acc_valid) begin
                writing <= 1'b1;
                idx     <= '0;
                sat_run <= 1'b0;
            end else if (writing) begin
                idx     <= idx + 1'b1;
                sat_run <= sat_run | row_clip;
                if (idx == k_width'(mm_size - 1)) begin
                    writing   <= 1'b0;
                    done      <= 1'b1;
                    saturated <= sat_run | row_clip;
                end
            end
        end
    end

    assign c_en   = writing;
    assign c_addr = address_c + awidth'(idx) * awidth'(stride_c);

    // Clip each element of the current row to the signed 8-bit range.
    always_comb begin : p_sat
        mm_acc_t elem;
        row_clip = 1'b0;
        for (int j = 0; j < mm_size; j++) begin
            elem = rows_q[idx][j];
            if (elem > mm_acc_t'(elem_max)) begin
                c_data[j] = dwidth'(elem_max);
                row_clip  = 1'b1;
            end else if (elem < mm_acc_t'(elem_min)) begin
                c_data[j] = dwidth'(elem_min);
                row_clip  = 1'b1;
            end else begin
                c_data[j] = elem[dwidth-1:0];
            end
        end
    end

    // The latched rows must not be replaced mid write-out.
    assert property (@(posedge pclk) disable iff (!rst_n)
        acc_valid |-> !writing);

endmodule

//--- src/mm_systolic_execute.sv
/* Execute stage of the accelerator.
   Fetches A columns and B rows, skews them into a 4x4 output-stationary array. */
module mm_systolic_execute
    import mm_cfg_pkg::*;
(
    input  logic                         pclk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [awidth-1:0]            address_a,
    input  logic [awidth-1:0]            address_b,
    input  logic [stride_width-1:0]      stride_a,
    input  logic [stride_width-1:0]      stride_b,
    output logic                         a_en,
    output logic [awidth-1:0]            a_addr,
    output logic                         b_en,
    output logic [awidth-1:0]            b_addr,
    input  mm_row_t                      a_data,
    input  mm_row_t                      b_data,
    output logic                         acc_valid,
    output mm_acc_row_t [mm_size-1:0]    acc_rows
);

    logic                   fetching;
    logic                   draining;
    logic                   rd_valid;
    logic [k_width-1:0]     k;
    logic [drain_width-1:0] drain_cnt;

    // Horizontal A links with valid, vertical B links.
    logic signed [dwidth-1:0] a_h [mm_size][mm_size+1];
    logic                     v_h [mm_size][mm_size+1];
    logic signed [dwidth-1:0] b_v [mm_size+1][mm_size];

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            fetching  <= 1'b0;
            draining  <= 1'b0;
            rd_valid  <= 1'b0;
            k         <= '0;
            drain_cnt <= '0;
        end else begin
            // Read data follows the enable by one cycle.
            rd_valid <= fetching;
            if (start) begin
                fetching <= 1'b1;
                k        <= '0;
            end else if (fetching) begin
                k <= k + 1'b1;
                if (k == k_width'(mm_size - 1)) begin
                    fetching  <= 1'b0;
                    draining  <= 1'b1;
                    drain_cnt <= drain_width'(drain_cycles);
                end
            end
            if (draining) begin
                if (drain_cnt == '0) begin
                    draining <= 1'b0;
                end else begin
                    drain_cnt <= drain_cnt - 1'b1;
                end
            end
        end
    end

    assign a_en   = fetching;
    assign b_en   = fetching;
    assign a_addr = address_a + awidth'(k) * awidth'(stride_a);
    assign b_addr = address_b + awidth'(k) * awidth'(stride_b);

    // Cell (3,3) took its last product on the previous edge.
    assign acc_valid = draining && (drain_cnt == '0);

    // Row i and column j enter the array i and j cycles late.
    for (genvar i = 0; i < mm_size; i++) begin : g_skew
        if (i == 0) begin : g_edge
            assign a_h[0][0] = a_data[0];
            assign v_h[0][0] = rd_valid;
            assign b_v[0][0] = b_data[0];
        end else begin : g_delay
            logic signed [dwidth-1:0] a_pipe [i];
            logic signed [dwidth-1:0] b_pipe [i];
            logic                     v_pipe [i];

            always_ff @(posedge pclk) begin
                a_pipe[0] <= a_data[i];
                b_pipe[0] <= b_data[i];
                for (int d = 1; d < i; d++) begin
                    a_pipe[d] <= a_pipe[d-1];
                    b_pipe[d] <= b_pipe[d-1];
                end
            end

            always_ff @(posedge pclk) begin
                if (!rst_n) begin
                    for (int d = 0; d < i; d++) begin
                        v_pipe[d] <= 1'b0;
                    end
                end else begin
                    v_pipe[0] <= rd_valid;
                    for (int d = 1; d < i; d++) begin
                        v_pipe[d] <= v_pipe[d-1];
                    end
                end
            end

            assign a_h[i][0] = a_pipe[i-1];
            assign v_h[i][0] = v_pipe[i-1];
            assign b_v[0][i] = b_pipe[i-1];
        end
    end

    // The valid bit rides along with A, B is aligned by the skew.
    for (genvar i = 0; i < mm_size; i++) begin : g_row
        for (genvar j = 0; j < mm_size; j++) begin : g_col
            mm_pe i_pe (
                .pclk      (pclk),
                .rst_n     (rst_n),
                .clear     (start),
                .a_in      (a_h[i][j]),
                .b_in      (b_v[i][j]),
                .valid_in  (v_h[i][j]),
                .a_out     (a_h[i][j+1]),
                .b_out     (b_v[i+1][j]),
                .valid_out (v_h[i][j+1]),
                .acc       (acc_rows[i][j])
            );
        end
    end

    // A new start would clear the array mid-run.
    assert property (@(posedge pclk) disable iff (!rst_n)
        start |-> !fetching && !draining);

endmodule

//--- test/mm_patterns.mem
// Each record is 17 words: addr_a addr_b addr_c strides (c.b.a bytes),
// then A columns 0-3, B rows 0-3, expected C rows 0-3 and the saturation bit.

// Identity A, so C equals B. Negative elements, unit strides.
00000000
00000010
00000020
00010101
00000001
00000100
00010000
01000000
04030201
FFFEFDFC
7F80107F
00000000
04030201
FFFEFDFC
7F80107F
00000000
00000000

// All-ones A with extreme B. Every element clips, relocated and strided.
00000100
00000200
00000300
00030804
01010101
01010101
01010101
01010101
80807F7F
80807F7F
80807F7F
80807F7F
80807F7F
80807F7F
80807F7F
80807F7F
00000001

// Mixed signs within range, which also clears the saturation bit.
00000040
00000080
000000C0
00100502
01000002
0000FF01
00030000
FE000000
04030201
08F906FB
EC14F60A
070005FD
10FF0AFD
F807FA05
C43CE21E
F603F807
00000000

//--- test/tb_matrix_multiplication.sv
/* Testbench for the matrix multiplication accelerator.
   Replays pattern records through APB and memory models and checks C and status. */
module tb_matrix_multiplication
    import mm_cfg_pkg::*;
    import mm_regs_pkg::*;
;

    localparam int num_records    = 3;
    localparam int rec_words      = 17;
    localparam int timeout_cycles = num_records * 200 + 100;
    localparam int mem_depth      = 2 ** awidth;

    logic                  pclk = 1'b0;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_awidth-1:0] paddr;
    logic [apb_dwidth-1:0] pwdata;
    logic [apb_dwidth-1:0] prdata;
    logic                  a_en;
    logic [awidth-1:0]     a_addr;
    mm_row_t               a_data = '0;
    logic                  b_en;
    logic [awidth-1:0]     b_addr;
    mm_row_t               b_data = '0;
    logic                  c_en;
    logic [awidth-1:0]     c_addr;
    mm_row_t               c_data;

    logic [31:0] pat [0:num_records*rec_words-1];
    mm_row_t     mem_a [mem_depth];
    mm_row_t     mem_b [mem_depth];
    mm_row_t     mem_c [mem_depth];
    logic        clear_c;
    int          c_writes = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h1cd5_91ea;

    matrix_multiplication i_matrix_multiplication (.*);

    always #20 pclk = ~pclk;

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", timeout_cycles);
        end
    end

    // Memories A and B answer one cycle after the enable.
    always @(posedge pclk) begin
        if (a_en) a_data <= mem_a[a_addr];
        if (b_en) b_data <= mem_b[b_addr];
    end

    // Memory C is refilled with an address pattern between records.
    always @(posedge pclk) begin
        if (clear_c) begin
            for (int a = 0; a < mem_depth; a++) begin
                mem_c[a] <= fill_word(awidth'(a));
            end
        end else if (c_en) begin
            mem_c[c_addr] <= c_data;
            c_writes      <= c_writes + 1;
        end
    end

    function automatic mm_row_t fill_word(input logic [awidth-1:0] addr);
        return {6'h2a, addr, 6'h15, ~addr};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    task automatic report_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic check_row(input string name, input mm_row_t expected, input mm_row_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic apb_write(input logic [apb_awidth-1:0] addr, input logic [31:0] data);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge pclk);
        penable <= 1'b1;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // Read data is sampled mid-cycle in the access phase.
    task automatic apb_read(input logic [apb_awidth-1:0] addr, output logic [31:0] data);
        @(posedge pclk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge pclk);
        penable <= 1'b1;
        @(negedge pclk);
        data = prdata;
        @(posedge pclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic random_idle();
        logic [2:0] n;
        n = '0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            n    = {n[1:0], lfsr[0]};
        end
        repeat (n) @(posedge pclk);
    endtask

    task automatic run_record(input int r);
        int          base;
        int          writes_before;
        logic [31:0] rd;
        logic [31:0] exp_status;
        mm_row_t     exp_row;
        base = r * rec_words;
        for (int k = 0; k < mm_size; k++) begin
            mem_a[awidth'(pat[base] + k * 32'(pat[base+3][7:0]))]   = pat[base+4+k];
            mem_b[awidth'(pat[base+1] + k * 32'(pat[base+3][15:8]))] = pat[base+8+k];
        end
        clear_c <= 1'b1;
        @(posedge pclk);
        clear_c <= 1'b0;
        apb_write(reg_addr_a, pat[base]);
        apb_write(reg_addr_b, pat[base+1]);
        apb_write(reg_addr_c, pat[base+2]);
        apb_write(reg_strides, pat[base+3]);
        apb_read(reg_addr_a, rd);
        check_word("prdata addr_a", pat[base], rd);
        apb_read(reg_addr_b, rd);
        check_word("prdata addr_b", pat[base+1], rd);
        apb_read(reg_addr_c, rd);
        check_word("prdata addr_c", pat[base+2], rd);
        apb_read(reg_strides, rd);
        check_word("prdata strides", pat[base+3], rd);
        apb_read(8'h18, rd);
        check_word("prdata unmapped", 32'h0, rd);
        random_idle();
        writes_before = c_writes;
        apb_write(reg_ctrl, 32'h1);
        apb_read(reg_status, rd);
        check_word("prdata status busy", 32'h4, rd);
        // A second start while busy must be dropped.
        apb_write(reg_ctrl, 32'h1);
        rd = '0;
        while (!rd[status_done_bit]) begin
            apb_read(reg_status, rd);
        end
        exp_status                 = '0;
        exp_status[status_done_bit] = 1'b1;
        exp_status[status_sat_bit]  = pat[base+16][0];
        check_word("prdata status done", exp_status, rd);
        repeat (24) @(posedge pclk);
        check_word("c_en write count", 32'd4, 32'(c_writes - writes_before));
        for (int a = 0; a < mem_depth; a++) begin
            exp_row = fill_word(awidth'(a));
            for (int i = 0; i < mm_size; i++) begin
                if (awidth'(a) == awidth'(pat[base+2] + i * 32'(pat[base+3][23:16]))) begin
                    exp_row = pat[base+12+i];
                end
            end
            check_row($sformatf("mem_c[%0h]", a), exp_row, mem_c[a]);
        end
    endtask

    initial begin
        logic [31:0] rd;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        clear_c <= 1'b0;
        rst_n   <= 1'b0;
        for (int w = 0; w < num_records * rec_words; w++) begin
            pat[w] = '1;
        end
        $readmemh("test/mm_patterns.mem", pat);
        if (pat[num_records*rec_words-1] === '1) begin
            $display("SIMULATION FAILED");
            $fatal(1, "The pattern file could not be read completely");
        end
        repeat (2) @(posedge pclk);
        rst_n <= 1'b1;
        apb_read(reg_status, rd);
        check_word("prdata status reset", 32'h0, rd);
        for (int r = 0; r < num_records; r++) begin
            run_record(r);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
